// ==== hdl/conv_macros.svh ====
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Line rows processed side by side, each row is fed by two line streams
`define CONV_N_ROW 2
// Output columns produced per pass
`define CONV_N_COL 2
// Filters evaluated in parallel by the sum-of-products array
`define CONV_NPF 2

// Stream counts derived from the array shape
`define CONV_N_LINE (2 * `CONV_N_ROW)
`define CONV_N_FILT (`CONV_NPF * `CONV_N_COL)
// Line streams sit on the low indices and filter streams on the high ones
`define CONV_N_STREAMS (`CONV_N_LINE + `CONV_N_FILT)

// Address and burst length widths
`define CONV_ADDR_W 32
`define CONV_LEN_W 12

// One weight beat per tap of a 3x3 kernel for every parallel filter
`define CONV_N_WEIGHTS (`CONV_NPF * 9)
// Field widths of the beat indices
`define CONV_TAP_W 5
`define CONV_FIDX_W 2
`define CONV_RIDX_W 1

`endif

// ==== hdl/conv_cfg_pkg.sv ====
`default_nettype none

`include "conv_macros.svh"

package conv_cfg_pkg;

  // Job description supplied by the host, held stable while the job is busy
  typedef struct packed {
    // Address of the first weight beat
    logic [`CONV_ADDR_W-1:0] weight_base;
    // Address of filter stream zero
    logic [`CONV_ADDR_W-1:0] filt_base;
    // Address of line stream zero
    logic [`CONV_ADDR_W-1:0] line_base;
    // Offset between neighbouring streams of the same kind
    logic [`CONV_ADDR_W-1:0] stream_pitch;
    // Step between consecutive beats of one burst
    logic [`CONV_ADDR_W-1:0] stride;
    // Beats per filter stream
    logic [`CONV_LEN_W-1:0]  filt_len;
    // Beats per line stream
    logic [`CONV_LEN_W-1:0]  line_len;
  } job_cfg_t;

  // Sequencer states, in the order a job walks through them
  typedef enum logic [1:0] {
    IDLE,
    START1,
    START2,
    RUN
  } wrap_state_t;

endpackage

`default_nettype wire

// ==== hdl/conv_stream_pkg.sv ====
`default_nettype none

`include "conv_macros.svh"

package conv_stream_pkg;

  // Weight address beat, tap counts through all kernels of the job
  typedef struct packed {
    logic [`CONV_ADDR_W-1:0] addr;
    logic [`CONV_TAP_W-1:0]  tap;
  } weight_beat_t;

  // Filter stream beat, idx is the filter stream number
  typedef struct packed {
    logic [`CONV_ADDR_W-1:0] addr;
    logic [`CONV_FIDX_W-1:0] idx;
    logic                    last;
  } filt_beat_t;

  // Line stream beat, idx is the row the stream feeds
  typedef struct packed {
    logic [`CONV_ADDR_W-1:0] addr;
    logic [`CONV_RIDX_W-1:0] idx;
    logic                    last;
  } line_beat_t;

endpackage

`default_nettype wire

// ==== hdl/conv_wrapper_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_wrapper_fsm (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           job_en_i,
  input  logic                           preload_done_i,
  input  logic                           done_weightload_i,
  input  logic                           done_ctrl_i,
  input  logic [`CONV_N_STREAMS-1:0]     ready_i,
  output logic [`CONV_N_STREAMS-1:0]     req_start_o,
  output logic                           engine_start_o,
  output conv_cfg_pkg::wrap_state_t      state_o
);

  // Request masks, filter streams on the upper bits and line streams below
  localparam logic [`CONV_N_STREAMS-1:0] FILT_MASK =
    {{`CONV_N_FILT{1'b1}}, {`CONV_N_LINE{1'b0}}};
  localparam logic [`CONV_N_STREAMS-1:0] LINE_MASK =
    {{`CONV_N_FILT{1'b0}}, {`CONV_N_LINE{1'b1}}};

  conv_cfg_pkg::wrap_state_t state_q;
  // Set once the filter streams got their start pulse in START2
  logic                      filt_started_q;
  logic                      filt_ready;
  logic                      line_ready;

  // A group can be started only when every stream in it is idle
  assign filt_ready = &ready_i[`CONV_N_STREAMS-1:`CONV_N_LINE];
  assign line_ready = &ready_i[`CONV_N_LINE-1:0];

  assign state_o = state_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= conv_cfg_pkg::IDLE;
      filt_started_q <= 1'b0;
      req_start_o    <= '0;
      engine_start_o <= 1'b0;
    end else begin
      // Requests and the engine start are one cycle pulses
      req_start_o    <= '0;
      engine_start_o <= 1'b0;
      case (state_q)
        conv_cfg_pkg::IDLE: begin
          filt_started_q <= 1'b0;
          if (job_en_i) begin
            // Kick the weight loader and the run tracker together
            state_q        <= conv_cfg_pkg::START1;
            engine_start_o <= 1'b1;
          end
        end
        conv_cfg_pkg::START1: begin
          // Weights must be fully issued before any stream starts
          if (done_weightload_i) begin
            state_q <= conv_cfg_pkg::START2;
          end
        end
        conv_cfg_pkg::START2: begin
          if (!filt_started_q) begin
            if (filt_ready) begin
              req_start_o    <= FILT_MASK;
              filt_started_q <= 1'b1;
            end
          end else if (preload_done_i && job_en_i && line_ready) begin
            // Line data is in place, so the line streams may run
            req_start_o    <= LINE_MASK;
            filt_started_q <= 1'b0;
            state_q        <= conv_cfg_pkg::RUN;
          end
        end
        conv_cfg_pkg::RUN: begin
          // The tracker reports when every line beat has gone out
          if (done_ctrl_i) begin
            state_q <= conv_cfg_pkg::IDLE;
          end
        end
        default: begin
          state_q <= conv_cfg_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/weight_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module weight_loader (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          start_i,
  input  conv_cfg_pkg::job_cfg_t        cfg_i,
  output logic                          beat_valid_o,
  output conv_stream_pkg::weight_beat_t beat_o,
  output logic                          done_o
);

  // Index of the final tap of the job
  localparam logic [`CONV_TAP_W-1:0] LAST_TAP = `CONV_TAP_W'(`CONV_N_WEIGHTS - 1);

  logic [`CONV_TAP_W-1:0]  tap_q;
  logic [`CONV_ADDR_W-1:0] addr_q;

  // Tap counter and burst control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_valid_o <= 1'b0;
      tap_q        <= '0;
      done_o       <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        // First beat goes out in the cycle after the engine start
        beat_valid_o <= 1'b1;
        tap_q        <= '0;
      end else if (beat_valid_o) begin
        if (tap_q == LAST_TAP) begin
          beat_valid_o <= 1'b0;
          done_o       <= 1'b1;
        end else begin
          tap_q <= tap_q + 1'b1;
        end
      end
    end
  end

  // Address accumulator, weight_base plus tap times stride
  always_ff @(posedge clk) begin
    if (start_i) begin
      addr_q <= cfg_i.weight_base;
    end else if (beat_valid_o) begin
      addr_q <= addr_q + cfg_i.stride;
    end
  end

  assign beat_o.addr = addr_q;
  assign beat_o.tap  = tap_q;

endmodule

`default_nettype wire

// ==== hdl/addr_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module addr_streamer #(
  // Beat struct with addr, idx and last fields
  parameter type         beat_t     = conv_stream_pkg::line_beat_t,
  // Position of this stream within its group
  parameter int unsigned STREAM_IDX = 0
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    req_i,
  input  logic [`CONV_ADDR_W-1:0] base_i,
  input  logic [`CONV_ADDR_W-1:0] pitch_i,
  input  logic [`CONV_ADDR_W-1:0] stride_i,
  input  logic [`CONV_LEN_W-1:0]  len_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output beat_t                   beat_o
);

  logic [`CONV_LEN_W-1:0]  cnt_q;
  logic [`CONV_ADDR_W-1:0] addr_q;
  logic                    last_beat;

  assign last_beat = (cnt_q == len_i - `CONV_LEN_W'(1));

  // Beat counter, a burst of zero length leaves the stream idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_o <= 1'b0;
      cnt_q   <= '0;
    end else if (req_i && ready_o) begin
      valid_o <= (len_i != '0);
      cnt_q   <= '0;
    end else if (valid_o) begin
      if (last_beat) begin
        valid_o <= 1'b0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Start address of stream k is base plus k times pitch
  always_ff @(posedge clk) begin
    if (req_i && ready_o) begin
      addr_q <= base_i + `CONV_ADDR_W'(STREAM_IDX) * pitch_i;
    end else if (valid_o) begin
      addr_q <= addr_q + stride_i;
    end
  end

  // Idle means ready, ready drops with the first beat and returns after the last
  assign ready_o = !valid_o;

  always_comb begin
    beat_o      = '0;
    beat_o.addr = addr_q;
    // Index is the low bits of the stream number, sized to the struct field
    beat_o.idx  = $bits(beat_o.idx)'(STREAM_IDX);
    beat_o.last = valid_o && last_beat;
  end

endmodule

`default_nettype wire

// ==== hdl/run_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module run_tracker (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start_i,
  input  logic [`CONV_N_LINE-1:0] line_valid_i,
  input  logic [`CONV_LEN_W-1:0]  line_len_i,
  output logic                    done_o
);

  // Wide enough for every line stream at its longest burst
  localparam int unsigned CNT_W = `CONV_LEN_W + $clog2(`CONV_N_LINE) + 1;

  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_next;
  logic [CNT_W-1:0] total;
  // Armed from engine start until the single done pulse
  logic             armed_q;

  assign total = CNT_W'(line_len_i) * CNT_W'(`CONV_N_LINE);

  // Running count plus the line beats seen in this cycle
  always_comb begin
    cnt_next = cnt_q;
    for (int i = 0; i < `CONV_N_LINE; i++) begin
      cnt_next = cnt_next + CNT_W'(line_valid_i[i]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q   <= '0;
      armed_q <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        cnt_q   <= '0;
        armed_q <= 1'b1;
      end else begin
        cnt_q <= cnt_next;
        // Fire in the cycle after the final line beat was counted
        if (armed_q && (cnt_next == total)) begin
          done_o  <= 1'b1;
          armed_q <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/conv_seq_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_seq_top (
  input  logic                                             clk,
  input  logic                                             rst_n,
  input  logic                                             job_en_i,
  input  logic                                             preload_done_i,
  input  conv_cfg_pkg::job_cfg_t                           cfg_i,
  output logic                                             weight_valid_o,
  output conv_stream_pkg::weight_beat_t                    weight_beat_o,
  output logic [`CONV_N_FILT-1:0]                          filt_valid_o,
  output conv_stream_pkg::filt_beat_t [`CONV_N_FILT-1:0]   filt_beat_o,
  output logic [`CONV_N_LINE-1:0]                          line_valid_o,
  output conv_stream_pkg::line_beat_t [`CONV_N_LINE-1:0]   line_beat_o,
  output logic                                             busy_o,
  output conv_cfg_pkg::wrap_state_t                        state_o
);

  logic                        engine_start;
  logic                        done_weightload;
  logic                        done_ctrl;
  logic [`CONV_N_STREAMS-1:0]  req_start;
  logic [`CONV_N_STREAMS-1:0]  ready;

  assign busy_o = (state_o != conv_cfg_pkg::IDLE);

  conv_wrapper_fsm u_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .job_en_i          (job_en_i),
    .preload_done_i    (preload_done_i),
    .done_weightload_i (done_weightload),
    .done_ctrl_i       (done_ctrl),
    .ready_i           (ready),
    .req_start_o       (req_start),
    .engine_start_o    (engine_start),
    .state_o           (state_o)
  );

  weight_loader u_weight_loader (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (engine_start),
    .cfg_i        (cfg_i),
    .beat_valid_o (weight_valid_o),
    .beat_o       (weight_beat_o),
    .done_o       (done_weightload)
  );

  // Filter streams occupy the upper request and ready bits
  for (genvar f = 0; f < `CONV_N_FILT; f++) begin : g_filt
    addr_streamer #(
      .beat_t     (conv_stream_pkg::filt_beat_t),
      .STREAM_IDX (f)
    ) u_filt (
      .clk (clk), .rst_n (rst_n),
      .req_i (req_start[`CONV_N_LINE+f]),
      .base_i (cfg_i.filt_base), .pitch_i (cfg_i.stream_pitch),
      .stride_i (cfg_i.stride), .len_i (cfg_i.filt_len),
      .ready_o (ready[`CONV_N_LINE+f]),
      .valid_o (filt_valid_o[f]), .beat_o (filt_beat_o[f])
    );
  end

  // Line stream k serves row k modulo the row count
  for (genvar l = 0; l < `CONV_N_LINE; l++) begin : g_line
    addr_streamer #(
      .beat_t     (conv_stream_pkg::line_beat_t),
      .STREAM_IDX (l)
    ) u_line (
      .clk (clk), .rst_n (rst_n),
      .req_i (req_start[l]),
      .base_i (cfg_i.line_base), .pitch_i (cfg_i.stream_pitch),
      .stride_i (cfg_i.stride), .len_i (cfg_i.line_len),
      .ready_o (ready[l]),
      .valid_o (line_valid_o[l]), .beat_o (line_beat_o[l])
    );
  end

  run_tracker u_run_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (engine_start),
    .line_valid_i (line_valid_o),
    .line_len_i   (cfg_i.line_len),
    .done_o       (done_ctrl)
  );

endmodule

`default_nettype wire

// ==== testbench/conv_seq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "conv_macros.svh"

module conv_seq_tb;

  localparam int N_JOBS = 6;

  logic                                                clk;
  logic                                                rst_n;
  logic                                                job_en_i;
  logic                                                preload_done_i;
  conv_cfg_pkg::job_cfg_t                              cfg_i;
  logic                                                weight_valid_o;
  conv_stream_pkg::weight_beat_t                       weight_beat_o;
  logic [`CONV_N_FILT-1:0]                             filt_valid_o;
  conv_stream_pkg::filt_beat_t [`CONV_N_FILT-1:0]      filt_beat_o;
  logic [`CONV_N_LINE-1:0]                             line_valid_o;
  conv_stream_pkg::line_beat_t [`CONV_N_LINE-1:0]      line_beat_o;
  logic                                                busy_o;
  conv_cfg_pkg::wrap_state_t                           state_o;

  // Cycle count since time zero that advances on every rising edge
  int          cyc = 0;
  int          cyc_limit = 0;
  int          errors = 0;
  int          tests = 0;
  logic [31:0] lfsr_q = 32'hc1e55eaa;

  // Job configurations and preload delays are drawn before reset is released
  conv_cfg_pkg::job_cfg_t job_cfg [N_JOBS];
  int                     job_delay [N_JOBS];

  // Reference model state of the job in flight
  logic job_active = 1'b0;
  logic preload_seen = 1'b0;
  logic filt_seen = 1'b0;
  int   job_cyc = 0;
  int   last_line_cyc = 0;
  int   w_cnt = 0;
  int   filt_cnt [`CONV_N_FILT];
  int   line_cnt [`CONV_N_LINE];

  conv_seq_top dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .job_en_i       (job_en_i),
    .preload_done_i (preload_done_i),
    .cfg_i          (cfg_i),
    .weight_valid_o (weight_valid_o),
    .weight_beat_o  (weight_beat_o),
    .filt_valid_o   (filt_valid_o),
    .filt_beat_o    (filt_beat_o),
    .line_valid_o   (line_valid_o),
    .line_beat_o    (line_beat_o),
    .busy_o         (busy_o),
    .state_o        (state_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= cyc_limit) begin
      $display("Timeout: the jobs did not finish within %0d cycles", cyc_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %0t %s got %h expected %h", $time, sig, got, exp);
    errors++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    errors++;
  endtask

  // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int b = 0; b < n; b++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      bits   = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // Beat i of stream k sits at base plus k pitches plus i strides
  function automatic logic [31:0] stream_addr(input logic [31:0] base, input int k,
                                              input int i);
    return base + 32'(k) * cfg_i.stream_pitch + 32'(i) * cfg_i.stride;
  endfunction

  function automatic logic lines_complete();
    for (int l = 0; l < `CONV_N_LINE; l++) begin
      if (line_cnt[l] != int'(cfg_i.line_len)) return 1'b0;
    end
    return 1'b1;
  endfunction

  // In IDLE no weight or line beat may be on the outputs
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    (state_o == conv_cfg_pkg::IDLE) |-> (!weight_valid_o && line_valid_o == '0))
    else report_error("weight or line beat while state_o is IDLE");

  // A job only starts from an edge that saw job_en_i high
  start_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy_o) |-> $past(job_en_i))
    else report_error("busy_o rose although job_en_i was low");

  task automatic check_weight_beat();
    if (!job_active || w_cnt >= `CONV_N_WEIGHTS) begin
      report_error("weight beat outside the expected burst");
    end else begin
      // The first beat comes two cycles after job_en_i went high and the rest follow
      assert (cyc == job_cyc + 2 + w_cnt)
        else report_mismatch("weight_valid_o cycle", cyc, job_cyc + 2 + w_cnt);
      assert (weight_beat_o.addr == cfg_i.weight_base + 32'(w_cnt) * cfg_i.stride)
        else report_mismatch("weight_beat_o.addr", weight_beat_o.addr,
                             cfg_i.weight_base + 32'(w_cnt) * cfg_i.stride);
      assert (int'(weight_beat_o.tap) == w_cnt)
        else report_mismatch("weight_beat_o.tap", weight_beat_o.tap, w_cnt);
      // Weights are loaded while the FSM sits in START1
      assert (state_o == conv_cfg_pkg::START1)
        else report_mismatch("state_o", state_o, conv_cfg_pkg::START1);
    end
    w_cnt++;
  endtask

  task automatic check_filt_beat(input int f);
    int          i;
    logic [31:0] exp_addr;
    logic        exp_last;
    i         = filt_cnt[f];
    filt_seen = 1'b1;
    if (!job_active || i >= int'(cfg_i.filt_len)) begin
      report_error($sformatf("filter stream %0d issued a beat beyond filt_len", f));
    end else begin
      exp_addr = stream_addr(cfg_i.filt_base, f, i);
      exp_last = (i == int'(cfg_i.filt_len) - 1);
      assert (filt_beat_o[f].addr == exp_addr)
        else report_mismatch($sformatf("filt_beat_o[%0d].addr", f),
                             filt_beat_o[f].addr, exp_addr);
      assert (int'(filt_beat_o[f].idx) == f)
        else report_mismatch($sformatf("filt_beat_o[%0d].idx", f), filt_beat_o[f].idx, f);
      assert (filt_beat_o[f].last == exp_last)
        else report_mismatch($sformatf("filt_beat_o[%0d].last", f),
                             filt_beat_o[f].last, exp_last);
    end
    filt_cnt[f]++;
  endtask

  task automatic check_line_beat(input int l);
    int          i;
    logic [31:0] exp_addr;
    logic        exp_last;
    i = line_cnt[l];
    assert (preload_seen) else report_error("line beat before preload_done_i was high");
    assert (filt_seen) else report_error("line beat before the first filter beat");
    if (!job_active || i >= int'(cfg_i.line_len)) begin
      report_error($sformatf("line stream %0d issued a beat beyond line_len", l));
    end else begin
      exp_addr = stream_addr(cfg_i.line_base, l, i);
      exp_last = (i == int'(cfg_i.line_len) - 1);
      assert (line_beat_o[l].addr == exp_addr)
        else report_mismatch($sformatf("line_beat_o[%0d].addr", l),
                             line_beat_o[l].addr, exp_addr);
      // Row index is the stream number modulo the row count
      assert (int'(line_beat_o[l].idx) == l % `CONV_N_ROW)
        else report_mismatch($sformatf("line_beat_o[%0d].idx", l),
                             line_beat_o[l].idx, l % `CONV_N_ROW);
      assert (line_beat_o[l].last == exp_last)
        else report_mismatch($sformatf("line_beat_o[%0d].last", l),
                             line_beat_o[l].last, exp_last);
      // Line beats only run while the FSM waits for the tracker in RUN
      assert (state_o == conv_cfg_pkg::RUN)
        else report_mismatch("state_o", state_o, conv_cfg_pkg::RUN);
    end
    line_cnt[l]++;
    last_line_cyc = cyc;
  endtask

  // Outputs are sampled mid cycle away from both edges
  always @(negedge clk) begin
    if (rst_n) begin
      if (preload_done_i) preload_seen = 1'b1;
      if (weight_valid_o) check_weight_beat();
      for (int f = 0; f < `CONV_N_FILT; f++) begin
        if (filt_valid_o[f]) check_filt_beat(f);
      end
      for (int l = 0; l < `CONV_N_LINE; l++) begin
        if (line_valid_o[l]) check_line_beat(l);
      end
    end
  end

  task automatic make_jobs();
    cyc_limit = 300;
    for (int j = 0; j < N_JOBS; j++) begin
      job_cfg[j].weight_base  = take_bits(32);
      job_cfg[j].filt_base    = take_bits(32);
      job_cfg[j].line_base    = take_bits(32);
      job_cfg[j].stream_pitch = take_bits(12);
      job_cfg[j].stride       = take_bits(6) << 2;
      job_cfg[j].filt_len     = `CONV_LEN_W'(1 + take_bits(4));
      job_cfg[j].line_len     = `CONV_LEN_W'(1 + take_bits(5));
      // Odd jobs hold the preload back past the end of the weight load
      job_delay[j] = int'(take_bits(5)) + ((j % 2 == 1) ? 24 : 0);
      cyc_limit += `CONV_N_WEIGHTS + int'(job_cfg[j].filt_len)
                   + int'(job_cfg[j].line_len) + job_delay[j] + 20;
    end
  endtask

  task automatic check_idle();
    int err_start;
    err_start = errors;
    repeat (10) begin
      @(posedge clk);
      #2;
      assert (!busy_o) else report_mismatch("busy_o", busy_o, 0);
      assert (state_o == conv_cfg_pkg::IDLE) else report_mismatch("state_o", state_o, 0);
      assert (!weight_valid_o) else report_mismatch("weight_valid_o", weight_valid_o, 0);
      assert (filt_valid_o == '0) else report_mismatch("filt_valid_o", filt_valid_o, 0);
      assert (line_valid_o == '0) else report_mismatch("line_valid_o", line_valid_o, 0);
    end
    tests++;
    $display("Idle after reset: %0d errors", errors - err_start);
  endtask

  task automatic run_job(input int j);
    int err_start;
    err_start     = errors;
    cfg_i         = job_cfg[j];
    w_cnt         = 0;
    preload_seen  = 1'b0;
    filt_seen     = 1'b0;
    last_line_cyc = 0;
    foreach (filt_cnt[f]) filt_cnt[f] = 0;
    foreach (line_cnt[l]) line_cnt[l] = 0;
    job_cyc        = cyc;
    job_active     = 1'b1;
    job_en_i       = 1'b1;
    preload_done_i = (job_delay[j] == 0);
    @(posedge clk);
    #2;
    while (busy_o) begin
      if (cyc - job_cyc >= job_delay[j]) preload_done_i = 1'b1;
      @(posedge clk);
      #2;
    end
    // The host releases enable and preload together with the fall of busy_o
    job_en_i       = 1'b0;
    preload_done_i = 1'b0;
    assert (lines_complete()) else report_error("busy_o fell before all line beats were issued");
    assert (cyc - last_line_cyc <= 2)
      else report_mismatch("busy_o fall delay", cyc - last_line_cyc, 2);
    // Long filter bursts may still run after busy_o falls
    while (filt_valid_o != '0) begin
      @(posedge clk);
      #2;
    end
    job_active = 1'b0;
    assert (w_cnt == `CONV_N_WEIGHTS)
      else report_mismatch("weight beat count", w_cnt, `CONV_N_WEIGHTS);
    for (int f = 0; f < `CONV_N_FILT; f++) begin
      assert (filt_cnt[f] == int'(cfg_i.filt_len))
        else report_mismatch($sformatf("filter stream %0d beat count", f),
                             filt_cnt[f], cfg_i.filt_len);
    end
    for (int l = 0; l < `CONV_N_LINE; l++) begin
      assert (line_cnt[l] == int'(cfg_i.line_len))
        else report_mismatch($sformatf("line stream %0d beat count", l),
                             line_cnt[l], cfg_i.line_len);
    end
    tests++;
    $display("Job %0d: filt_len %0d line_len %0d preload delay %0d, %0d errors", j,
             cfg_i.filt_len, cfg_i.line_len, job_delay[j], errors - err_start);
  endtask

  initial begin
    rst_n          = 1'b0;
    job_en_i       = 1'b0;
    preload_done_i = 1'b0;
    cfg_i          = '0;
    make_jobs();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_idle();
    // Jobs follow each other without a gap to catch stale counters
    for (int j = 0; j < N_JOBS; j++) begin
      run_job(j);
    end
    $display("Summary: %0d tests run, %0d checks failed", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_seq_top.f ====
+incdir+hdl
hdl/conv_cfg_pkg.sv
hdl/conv_stream_pkg.sv
hdl/conv_wrapper_fsm.sv
hdl/weight_loader.sv
hdl/addr_streamer.sv
hdl/run_tracker.sv
hdl/conv_seq_top.sv
testbench/conv_seq_tb.sv

// ==== Bender.yml ====
package:
  name: conv_seq

export_include_dirs:
  - hdl

sources:
  # Packages first, then the modules bottom up
  - hdl/conv_cfg_pkg.sv
  - hdl/conv_stream_pkg.sv
  - hdl/conv_wrapper_fsm.sv
  - hdl/weight_loader.sv
  - hdl/addr_streamer.sv
  - hdl/run_tracker.sv
  - hdl/conv_seq_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/conv_seq_tb.sv
